// ==== src/adc_ctrl_consts.svh ====
`ifndef ADC_CTRL_CONSTS_SVH
`define ADC_CTRL_CONSTS_SVH

// one 3-wire frame is 8 address bits followed by 16 data bits.
`define ADC3W_FRAME_BITS 24

// half periods of the generated clocks, counted in wb_clk_i cycles.
`define ADC3W_CLK_DIV 2
`define PS_CLK_DIV 2

// signed MMCM phase position.
`define PS_POS_BITS 16

// word offsets, decoded from wb_adr_i[4:2].
`define REG_CTRL 3'd0
`define REG_SPI 3'd1
`define REG_PS 3'd2
`define REG_STATUS 3'd3

`endif

// ==== src/adc_ctrl_pkg.sv ====
`include "adc_ctrl_consts.svh"

package adc_ctrl_pkg;

  // commands from the register stage to the two engines.
  typedef enum logic [1:0] {
    OP_SPI_WRITE = 2'd0,
    OP_PS_INC    = 2'd1,
    OP_PS_DEC    = 2'd2
  } adc_op_e;

  // offsets 4 to 7 all decode to IDX_BAD.
  typedef enum logic [2:0] {
    IDX_CTRL   = `REG_CTRL,
    IDX_SPI    = `REG_SPI,
    IDX_PS     = `REG_PS,
    IDX_STATUS = `REG_STATUS,
    IDX_BAD    = 3'd4
  } reg_idx_e;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LOW,
    SPI_HIGH,
    SPI_END
  } spi_state_e;

  typedef enum logic [1:0] {
    PS_IDLE,
    PS_PULSE,
    PS_WAIT,
    PS_NEXT
  } ps_state_e;

endpackage

// ==== src/adc_cmd_if.sv ====
`timescale 1ns/1ps
`include "adc_ctrl_consts.svh"

interface adc_cmd_if;

  // one-cycle command pulse with its opcode and argument.
  logic                                   cmd_valid;
  adc_ctrl_pkg::adc_op_e                  cmd_op;
  logic [`ADC3W_FRAME_BITS-1:0]           cmd_arg;

  // engine status back to the register stage.
  logic                                   spi_busy;
  logic                                   ps_busy;
  logic signed [`PS_POS_BITS-1:0]         ps_pos;

  modport issuer (output cmd_valid, cmd_op, cmd_arg,
                  input  spi_busy, ps_busy, ps_pos);

  modport spi_engine (input  cmd_valid, cmd_op, cmd_arg,
                      output spi_busy);

  modport ps_engine (input  cmd_valid, cmd_op, cmd_arg,
                     output ps_busy, ps_pos);

endinterface

// ==== src/wb_adc_regs.sv ====
`timescale 1ns/1ps
`include "adc_ctrl_consts.svh"

module wb_adc_regs
  import adc_ctrl_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  output logic        modepin_o,
  output logic        ddrb_o,
  output logic        mmcm_reset_o,
  adc_cmd_if.issuer   cmd
);

  reg_idx_e    reg_idx;
  logic        ack_q;
  logic        err_q;
  logic        req;
  logic        bad;
  logic [2:0]  ctrl_q;
  logic [31:0] rd_next;
  logic [31:0] rd_data_q;

  always_comb begin
    case (wb_adr_i[4:2])
      `REG_CTRL:   reg_idx = IDX_CTRL;
      `REG_SPI:    reg_idx = IDX_SPI;
      `REG_PS:     reg_idx = IDX_PS;
      `REG_STATUS: reg_idx = IDX_STATUS;
      default:     reg_idx = IDX_BAD;
    endcase
  end

  // a new request is only taken once the previous reply has gone.
  assign req = wb_cyc_i && wb_stb_i && !ack_q && !err_q;

  always_comb begin
    bad = 1'b0;
    if (reg_idx == IDX_BAD) begin
      bad = 1'b1;
    end else if (wb_we_i) begin
      case (reg_idx)
        IDX_SPI:    bad = cmd.spi_busy;
        IDX_PS:     bad = cmd.ps_busy;
        IDX_STATUS: bad = 1'b1;
        default:    bad = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (reg_idx)
      IDX_CTRL:   rd_next = {29'd0, ctrl_q};
      IDX_STATUS: rd_next = {cmd.ps_pos, 14'd0, cmd.ps_busy, cmd.spi_busy};
      default:    rd_next = 32'd0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q         <= 1'b0;
      err_q         <= 1'b0;
      ctrl_q        <= 3'd0;
      cmd.cmd_valid <= 1'b0;
    end else begin
      ack_q         <= 1'b0;
      err_q         <= 1'b0;
      cmd.cmd_valid <= 1'b0;
      if (req) begin
        if (bad) begin
          err_q <= 1'b1;
        end else begin
          ack_q     <= 1'b1;
          rd_data_q <= wb_we_i ? 32'd0 : rd_next;
          if (wb_we_i) begin
            case (reg_idx)
              IDX_CTRL: begin
                if (wb_sel_i[0]) ctrl_q <= wb_dat_i[2:0];
              end
              IDX_SPI: begin
                cmd.cmd_valid <= 1'b1;
                cmd.cmd_op    <= OP_SPI_WRITE;
                cmd.cmd_arg   <= wb_dat_i[`ADC3W_FRAME_BITS-1:0];
              end
              IDX_PS: begin
                // a zero step count is acknowledged but starts nothing.
                if (wb_dat_i[15:0] != 16'd0) begin
                  cmd.cmd_valid <= 1'b1;
                  cmd.cmd_op    <= wb_dat_i[16] ? OP_PS_INC : OP_PS_DEC;
                  cmd.cmd_arg   <= {8'd0, wb_dat_i[15:0]};
                end
              end
              default: ;
            endcase
          end
        end
      end
    end
  end

  assign wb_ack_o     = ack_q;
  assign wb_err_o     = err_q;
  assign wb_dat_o     = ack_q ? rd_data_q : 32'd0;
  assign modepin_o    = ctrl_q[0];
  assign ddrb_o       = ctrl_q[1];
  assign mmcm_reset_o = ctrl_q[2];

endmodule

// ==== src/adc_3wire_serializer.sv ====
`timescale 1ns/1ps
`include "adc_ctrl_consts.svh"

module adc_3wire_serializer
  import adc_ctrl_pkg::*;
(
  input  logic          wb_clk_i,
  input  logic          wb_rst_i,
  adc_cmd_if.spi_engine cmd,
  output logic          adc3wire_clk_o,
  output logic          adc3wire_data_o,
  output logic          adc3wire_strobe_o
);

  localparam int N     = `ADC3W_FRAME_BITS;
  localparam int DIV_W = $clog2(`ADC3W_CLK_DIV + 1);
  localparam int BIT_W = $clog2(N + 1);

  spi_state_e       state;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [N-1:0]     shreg;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state             <= SPI_IDLE;
      div_cnt           <= '0;
      bit_cnt           <= '0;
      adc3wire_clk_o    <= 1'b0;
      adc3wire_data_o   <= 1'b0;
      adc3wire_strobe_o <= 1'b1;
    end else begin
      case (state)
        SPI_IDLE: begin
          if (cmd.cmd_valid && cmd.cmd_op == OP_SPI_WRITE) begin
            // the MSB goes straight to the pin, the rest waits in the shifter.
            shreg             <= {cmd.cmd_arg[N-2:0], 1'b0};
            adc3wire_data_o   <= cmd.cmd_arg[N-1];
            adc3wire_strobe_o <= 1'b0;
            div_cnt           <= '0;
            bit_cnt           <= BIT_W'(N - 1);
            state             <= SPI_LOW;
          end
        end
        SPI_LOW: begin
          if (div_cnt == DIV_W'(`ADC3W_CLK_DIV - 1)) begin
            div_cnt        <= '0;
            adc3wire_clk_o <= 1'b1;
            state          <= SPI_HIGH;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        SPI_HIGH: begin
          if (div_cnt == DIV_W'(`ADC3W_CLK_DIV - 1)) begin
            div_cnt        <= '0;
            adc3wire_clk_o <= 1'b0;
            if (bit_cnt == '0) begin
              state <= SPI_END;
            end else begin
              bit_cnt         <= bit_cnt - 1'b1;
              adc3wire_data_o <= shreg[N-1];
              shreg           <= shreg << 1;
              state           <= SPI_LOW;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        SPI_END: begin
          // strobe stays low for one more cycle of hold after the last clock.
          adc3wire_strobe_o <= 1'b1;
          adc3wire_data_o   <= 1'b0;
          state             <= SPI_IDLE;
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  assign cmd.spi_busy = (state != SPI_IDLE);

endmodule

// ==== src/mmcm_phase_stepper.sv ====
`timescale 1ns/1ps
`include "adc_ctrl_consts.svh"

module mmcm_phase_stepper
  import adc_ctrl_pkg::*;
(
  input  logic         wb_clk_i,
  input  logic         wb_rst_i,
  input  logic         mmcm_reset_i,
  adc_cmd_if.ps_engine cmd,
  output logic         psclk_o,
  output logic         psen_o,
  output logic         psincdec_o,
  input  logic         psdone_i
);

  localparam int DIV_W = $clog2(`PS_CLK_DIV + 1);

  ps_state_e        state;
  logic [DIV_W-1:0] div_cnt;
  logic [15:0]      steps_left;
  logic             ps_rise;

  // psclk rises on the cycle after this flag.
  assign ps_rise = (div_cnt == DIV_W'(`PS_CLK_DIV - 1)) && !psclk_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || state == PS_IDLE) begin
      div_cnt <= '0;
      psclk_o <= 1'b0;
    end else if (div_cnt == DIV_W'(`PS_CLK_DIV - 1)) begin
      div_cnt <= '0;
      psclk_o <= !psclk_o;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state      <= PS_IDLE;
      psen_o     <= 1'b0;
      psincdec_o <= 1'b0;
    end else begin
      case (state)
        PS_IDLE: begin
          if (cmd.cmd_valid && (cmd.cmd_op == OP_PS_INC || cmd.cmd_op == OP_PS_DEC)) begin
            steps_left <= cmd.cmd_arg[15:0];
            psincdec_o <= (cmd.cmd_op == OP_PS_INC);
            state      <= PS_PULSE;
          end
        end
        PS_PULSE: begin
          // psen spans one full psclk period, rising edge to rising edge.
          if (ps_rise) begin
            psen_o <= !psen_o;
            if (psen_o) state <= PS_WAIT;
          end
        end
        PS_WAIT: begin
          if (psdone_i) begin
            steps_left <= steps_left - 1'b1;
            state      <= PS_NEXT;
          end
        end
        PS_NEXT: state <= (steps_left == 16'd0) ? PS_IDLE : PS_PULSE;
        default: state <= PS_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || mmcm_reset_i) begin
      cmd.ps_pos <= '0;
    end else if (state == PS_WAIT && psdone_i) begin
      cmd.ps_pos <= psincdec_o ? cmd.ps_pos + 1'b1 : cmd.ps_pos - 1'b1;
    end
  end

  assign cmd.ps_busy = (state != PS_IDLE);

endmodule

// ==== src/wb_adc_controller.sv ====
`timescale 1ns/1ps

module wb_adc_controller (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  output logic        adc3wire_clk_o,
  output logic        adc3wire_data_o,
  output logic        adc3wire_strobe_o,
  output logic        modepin_o,
  output logic        ddrb_o,
  output logic        mmcm_reset_o,
  output logic        psclk_o,
  output logic        psen_o,
  output logic        psincdec_o,
  input  logic        psdone_i
);

  adc_cmd_if cmd ();

  wb_adc_regs i_regs (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .modepin_o    (modepin_o),
    .ddrb_o       (ddrb_o),
    .mmcm_reset_o (mmcm_reset_o),
    .cmd          (cmd.issuer)
  );

  adc_3wire_serializer i_serializer (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .cmd               (cmd.spi_engine),
    .adc3wire_clk_o    (adc3wire_clk_o),
    .adc3wire_data_o   (adc3wire_data_o),
    .adc3wire_strobe_o (adc3wire_strobe_o)
  );

  // the CTRL reset bit also clears the tracked phase position.
  mmcm_phase_stepper i_stepper (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .mmcm_reset_i (mmcm_reset_o),
    .cmd          (cmd.ps_engine),
    .psclk_o      (psclk_o),
    .psen_o       (psen_o),
    .psincdec_o   (psincdec_o),
    .psdone_i     (psdone_i)
  );

endmodule

// ==== verification/tb_wb_adc_controller.sv ====
`timescale 1ns/1ps
`include "adc_ctrl_consts.svh"

module tb_wb_adc_controller;

  localparam int MAX_LINES = 64;
  localparam int PSCLK_PERIOD = 2 * `PS_CLK_DIV;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic        adc3wire_clk_o;
  logic        adc3wire_data_o;
  logic        adc3wire_strobe_o;
  logic        modepin_o;
  logic        ddrb_o;
  logic        mmcm_reset_o;
  logic        psclk_o;
  logic        psen_o;
  logic        psincdec_o;
  logic        psdone_i;

  // one entry per trace line.
  logic [8*24-1:0] t_name [0:MAX_LINES-1];
  logic [8*8-1:0]  t_op   [0:MAX_LINES-1];
  logic [31:0]     t_off  [0:MAX_LINES-1];
  logic [31:0]     t_sel  [0:MAX_LINES-1];
  logic [31:0]     t_data [0:MAX_LINES-1];
  logic [8*4-1:0]  t_resp [0:MAX_LINES-1];
  logic [31:0]     t_exp  [0:MAX_LINES-1];
  int              n_lines;
  int unsigned     step_sum;

  int              err_count = 0;
  int              tests_ok = 0;
  int              tests_bad = 0;
  int unsigned     cycles = 0;
  int unsigned     cycle_limit = 32'hffff_ffff;
  logic [8*24-1:0] cur_name = "reset";

  logic [2:0]      ctrl_model = 3'd0;
  logic [23:0]     exp_frame = 24'd0;
  logic            exp_dir = 1'b0;
  int              frames_exp = 0;
  int              frames_seen = 0;
  int              steps_exp = 0;
  int              pulses_seen = 0;

  logic            prev_aclk = 1'b0;
  logic            prev_strobe = 1'b1;
  logic            prev_psen = 1'b0;
  logic            prev_psclk = 1'b0;
  int              psen_cycles = 0;
  int              psclk_rises = 0;
  logic            in_frame = 1'b0;
  logic [23:0]     frame_bits = 24'd0;
  int              bit_count = 0;
  int              done_wait = 0;
  logic            done_fire = 1'b0;
  logic [31:0]     lfsr_state = 32'h120e;

  wb_adc_controller i_dut (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_sel_i          (wb_sel_i),
    .wb_we_i           (wb_we_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .wb_err_o          (wb_err_o),
    .adc3wire_clk_o    (adc3wire_clk_o),
    .adc3wire_data_o   (adc3wire_data_o),
    .adc3wire_strobe_o (adc3wire_strobe_o),
    .modepin_o         (modepin_o),
    .ddrb_o            (ddrb_o),
    .mmcm_reset_o      (mmcm_reset_o),
    .psclk_o           (psclk_o),
    .psen_o            (psen_o),
    .psincdec_o        (psincdec_o),
    .psdone_i          (psdone_i)
  );

  initial wb_clk_i = 1'b0;
  always #5 wb_clk_i = ~wb_clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  always @(posedge wb_clk_i) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles while running %0s", cycles, cur_name);
      $display(">>> FAIL");
      $finish;
    end
  end

  // psdone is launched one cycle after the model's countdown expires.
  always @(posedge wb_clk_i) begin
    psdone_i <= wb_rst_i ? 1'b0 : done_fire;
  end

  always @(negedge wb_clk_i) begin : pin_monitor
    int delay;
    done_fire = 1'b0;
    if (wb_rst_i) begin
      in_frame  = 1'b0;
      bit_count = 0;
      done_wait = 0;
    end else begin
      if (!adc3wire_strobe_o && prev_strobe) begin
        in_frame  = 1'b1;
        bit_count = 0;
      end
      if (in_frame && adc3wire_clk_o && !prev_aclk) begin
        frame_bits = {frame_bits[22:0], adc3wire_data_o};
        bit_count  = bit_count + 1;
      end
      if (in_frame && adc3wire_strobe_o && !prev_strobe) begin
        in_frame    = 1'b0;
        frames_seen = frames_seen + 1;
        if (bit_count != 24) begin
          $display("%0s: frame ended after %0d clock edges instead of 24", cur_name, bit_count);
          err_count = err_count + 1;
        end else if (frame_bits !== exp_frame) begin
          $display("MISMATCH %0s frame expected %06h actual %06h", cur_name, exp_frame,
                   frame_bits);
          err_count = err_count + 1;
        end
      end
      if (psen_o && !prev_psen) begin
        pulses_seen = pulses_seen + 1;
        psen_cycles = 0;
        psclk_rises = 0;
        if (psincdec_o !== exp_dir) begin
          $display("MISMATCH %0s psincdec expected %0b actual %0b", cur_name, exp_dir,
                   psincdec_o);
          err_count = err_count + 1;
        end
      end
      // both edges of psen sit on a rising psclk edge.
      if (psen_o != prev_psen && !(psclk_o && !prev_psclk)) begin
        $display("%0s: psen changed away from a rising psclk edge", cur_name);
        err_count = err_count + 1;
      end
      if (prev_psen) begin
        psen_cycles = psen_cycles + 1;
        if (psclk_o && !prev_psclk) begin
          psclk_rises = psclk_rises + 1;
        end
      end
      if (done_wait != 0) begin
        done_wait = done_wait - 1;
        if (done_wait == 0) begin
          done_fire = 1'b1;
        end
      end
      // the MMCM answers 1 to 8 cycles after psen has dropped.
      if (!psen_o && prev_psen) begin
        if (psen_cycles != PSCLK_PERIOD) begin
          $display("MISMATCH %0s psen width expected %0d actual %0d", cur_name,
                   PSCLK_PERIOD, psen_cycles);
          err_count = err_count + 1;
        end
        if (psclk_rises != 1) begin
          $display("MISMATCH %0s psclk rises during psen expected 1 actual %0d", cur_name,
                   psclk_rises);
          err_count = err_count + 1;
        end
        delay = 0;
        for (int b = 0; b < 3; b++) begin
          delay      = delay * 2 + lfsr_state[0];
          lfsr_state = lfsr_next(lfsr_state);
        end
        done_wait = delay + 1;
      end
    end
    prev_aclk   = adc3wire_clk_o;
    prev_strobe = adc3wire_strobe_o;
    prev_psen   = psen_o;
    prev_psclk  = psclk_o;
  end

  task automatic load_trace();
    int              fd;
    int              n;
    logic [8*24-1:0] tok;
    logic [8*120-1:0] rest;
    n_lines  = 0;
    step_sum = 0;
    fd = $fopen("verification/adc_ctrl_trace.txt", "r");
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%s %h %h %h %s %h", t_op[n_lines], t_off[n_lines],
                      t_sel[n_lines], t_data[n_lines], t_resp[n_lines], t_exp[n_lines]);
          if (n == 6 && n_lines < MAX_LINES) begin
            t_name[n_lines] = tok;
            if (t_op[n_lines] == "W" && t_off[n_lines] == 32'd2) begin
              step_sum = step_sum + t_data[n_lines][15:0];
            end
            n_lines = n_lines + 1;
          end else begin
            $display("trace line %0s could not be parsed", tok);
            err_count = err_count + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic end_test(input int errs_before);
    if (err_count == errs_before) begin
      tests_ok = tests_ok + 1;
      $display("%0s: ok", cur_name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("%0s: failed", cur_name);
    end
  endtask

  task automatic bus_access(input logic we, input logic [2:0] off, input logic [3:0] sel,
                            input logic [31:0] data, output logic got_err,
                            output logic [31:0] rdata);
    int waits;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= {27'd0, off, 2'b00};
    wb_dat_i <= data;
    wb_sel_i <= sel;
    @(negedge wb_clk_i);
    waits = 1;
    while (!wb_ack_o && !wb_err_o) begin
      @(negedge wb_clk_i);
      waits = waits + 1;
    end
    if (wb_ack_o && wb_err_o) begin
      $display("%0s: ack and err were high together", cur_name);
      err_count = err_count + 1;
    end
    // the request is sampled on the first edge, the reply follows one cycle later.
    if (waits != 2) begin
      $display("%0s: reply came %0d cycles after the request instead of 1", cur_name,
               waits - 1);
      err_count = err_count + 1;
    end
    got_err = wb_err_o;
    rdata   = wb_dat_o;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic run_line(input int i);
    logic        got_err;
    logic        exp_err;
    logic [31:0] rdata;
    int          errs_before;
    cur_name    = t_name[i];
    errs_before = err_count;
    exp_err     = (t_resp[i] == "ERR");
    if (t_op[i] == "WAIT") begin
      rdata = t_data[i];
      while ((rdata & t_data[i]) != 32'd0) begin
        bus_access(1'b0, 3'd3, 4'hf, 32'd0, got_err, rdata);
        if (got_err) begin
          $display("%0s: STATUS read answered with err while polling", cur_name);
          err_count = err_count + 1;
          rdata = 32'd0;
        end
      end
    end else begin
      bus_access(t_op[i] == "W", t_off[i][2:0], t_sel[i][3:0], t_data[i], got_err, rdata);
      if (got_err !== exp_err) begin
        $display("MISMATCH %0s response expected %0s actual %0s", cur_name,
                 exp_err ? "ERR" : "ACK", got_err ? "ERR" : "ACK");
        err_count = err_count + 1;
      end
      if (t_op[i] == "R" && rdata !== t_exp[i]) begin
        $display("MISMATCH %0s read data expected %08h actual %08h", cur_name, t_exp[i],
                 rdata);
        err_count = err_count + 1;
      end
      if (t_op[i] == "W" && !got_err) begin
        case (t_off[i][2:0])
          3'd0: begin
            if (t_sel[i][0]) begin
              ctrl_model = t_data[i][2:0];
            end
            if ({mmcm_reset_o, ddrb_o, modepin_o} !== ctrl_model) begin
              $display("MISMATCH %0s pins expected %03b actual %03b", cur_name, ctrl_model,
                       {mmcm_reset_o, ddrb_o, modepin_o});
              err_count = err_count + 1;
            end
          end
          3'd1: begin
            exp_frame  = t_data[i][23:0];
            frames_exp = frames_exp + 1;
          end
          3'd2: begin
            if (t_data[i][15:0] != 16'd0) begin
              exp_dir   = t_data[i][16];
              steps_exp = steps_exp + t_data[i][15:0];
            end
          end
          default: ;
        endcase
      end
    end
    end_test(errs_before);
  endtask

  initial begin : main
    int errs_before;
    wb_rst_i = 1'b1;
    wb_adr_i = 32'd0;
    wb_dat_i = 32'd0;
    wb_sel_i = 4'd0;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    psdone_i = 1'b0;
    load_trace();
    if (n_lines == 0) begin
      $display("trace file verification/adc_ctrl_trace.txt is missing or empty");
      $display(">>> FAIL");
      $finish;
    end else begin
      cycle_limit = n_lines * 64 + step_sum * 200;
      repeat (4) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      @(negedge wb_clk_i);
      cur_name    = "reset_state";
      errs_before = err_count;
      if ({adc3wire_strobe_o, wb_ack_o, wb_err_o, adc3wire_clk_o, adc3wire_data_o, psen_o,
           psincdec_o, psclk_o, modepin_o, ddrb_o, mmcm_reset_o} !== 11'h400) begin
        $display("MISMATCH %0s outputs expected %011b actual %011b", cur_name, 11'h400,
                 {adc3wire_strobe_o, wb_ack_o, wb_err_o, adc3wire_clk_o, adc3wire_data_o,
                  psen_o, psincdec_o, psclk_o, modepin_o, ddrb_o, mmcm_reset_o});
        err_count = err_count + 1;
      end
      end_test(errs_before);
      for (int i = 0; i < n_lines; i++) begin
        run_line(i);
      end
      repeat (4) @(negedge wb_clk_i);
      cur_name    = "engine_totals";
      errs_before = err_count;
      if (frames_seen != frames_exp) begin
        $display("MISMATCH %0s frames expected %0d actual %0d", cur_name, frames_exp,
                 frames_seen);
        err_count = err_count + 1;
      end
      if (pulses_seen != steps_exp) begin
        $display("MISMATCH %0s psen pulses expected %0d actual %0d", cur_name, steps_exp,
                 pulses_seen);
        err_count = err_count + 1;
      end
      // with both engines idle psclk rests low.
      if (psclk_o !== 1'b0) begin
        $display("MISMATCH %0s idle psclk expected 0 actual %0b", cur_name, psclk_o);
        err_count = err_count + 1;
      end
      end_test(errs_before);
      $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, err_count);
      if (err_count == 0 && tests_bad == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== verification/adc_ctrl_trace.txt ====
# one bus operation per line, values in hex, offset is the word offset
# name op offset sel data resp rdata (rdata checked on R; WAIT polls STATUS until data bits clear)
rst_ctrl_rd    R    0 f 00000000 ACK 00000000
ctrl_wr        W    0 f 00000003 ACK 00000000
ctrl_rd        R    0 f 00000000 ACK 00000003
ctrl_nosel_wr  W    0 e 00000004 ACK 00000000
ctrl_nosel_rd  R    0 f 00000000 ACK 00000003
ctrl_clr       W    0 1 00000000 ACK 00000000
ctrl_clr_rd    R    0 f 00000000 ACK 00000000
spi_wr         W    1 f 0012a5c3 ACK 00000000
spi_busy_rd    R    3 f 00000000 ACK 00000001
spi_wr_busy    W    1 f 00ff0f0f ERR 00000000
spi_wait       WAIT 3 f 00000001 ACK 00000000
spi_wr2        W    1 f 00800001 ACK 00000000
spi_wait2      WAIT 3 f 00000001 ACK 00000000
ps_inc         W    2 f 00010003 ACK 00000000
ps_inc_wait    WAIT 3 f 00000002 ACK 00000000
ps_inc_rd      R    3 f 00000000 ACK 00030000
ps_dec         W    2 f 00000005 ACK 00000000
ps_dec_wait    WAIT 3 f 00000002 ACK 00000000
ps_dec_rd      R    3 f 00000000 ACK fffe0000
ps_inc2        W    2 f 00010004 ACK 00000000
ps_wr_busy     W    2 f 00000001 ERR 00000000
ps_inc2_wait   WAIT 3 f 00000002 ACK 00000000
ps_inc2_rd     R    3 f 00000000 ACK 00020000
mmcm_rst_wr    W    0 f 00000004 ACK 00000000
mmcm_rst_rd    R    3 f 00000000 ACK 00000000
mmcm_rst_clr   W    0 f 00000000 ACK 00000000
ps_zero        W    2 f 00010000 ACK 00000000
ps_zero_rd     R    3 f 00000000 ACK 00000000
status_wr      W    3 f 12345678 ERR 00000000
bad_wr4        W    4 f 00000001 ERR 00000000
bad_rd5        R    5 f 00000000 ERR 00000000
bad_rd7        R    7 f 00000000 ERR 00000000

// ==== all.f ====
+incdir+src
src/adc_ctrl_pkg.sv
src/adc_cmd_if.sv
src/wb_adc_regs.sv
src/adc_3wire_serializer.sv
src/mmcm_phase_stepper.sv
src/wb_adc_controller.sv
verification/tb_wb_adc_controller.sv
